//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - include_dirs:
      - common
    files:
      - common/mips_pkg.sv
      - common/fwd_if.sv
      - hdl/prog_loader.sv
      - fetch/if_stage.sv
      - decode/id_stage.sv
      - hdl/hazard_unit.sv
      - hdl/forward_unit.sv
      - execute/ex_stage.sv
      - memory/mem_wb_stage.sv
      - hdl/mips_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/tb_mips.sv

//--- common/fwd_if.sv
interface fwd_if
  import mips_pkg::*;
();

  // Instruction currently in EX
  reg_addr_t ex_rd;
  logic      ex_reg_write;
  logic      ex_mem_read;
  word_t     ex_value;

  // Instruction in MEM, value already includes load data
  reg_addr_t mem_rd;
  logic      mem_reg_write;
  word_t     mem_value;

  // Instruction in WB
  reg_addr_t wb_rd;
  logic      wb_reg_write;
  word_t     wb_value;

  modport producer_ex (
    output ex_rd, ex_reg_write, ex_mem_read, ex_value,
    input  mem_value, wb_value
  );

  modport producer_mem (
    output mem_rd, mem_reg_write, mem_value, wb_rd, wb_reg_write, wb_value
  );

  modport consumer (
    input ex_rd, ex_reg_write, ex_mem_read, ex_value,
    input mem_rd, mem_reg_write, mem_value, wb_rd, wb_reg_write, wb_value
  );

endinterface

//--- common/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Memory depths in 32-bit words
`define IMEM_WORDS 256
`define DMEM_WORDS 64

// Run control register, bit 0 is run
`define CTRL_ADDR 32'h1000

`endif

//--- common/mips_pkg.sv
`include "mips_cfg.svh"

package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [5:0]  funct_t;
  typedef logic [15:0] imm_t;
  typedef logic [$clog2(`IMEM_WORDS)-1:0] imem_addr_t;
  typedef logic [$clog2(`DMEM_WORDS)-1:0] dmem_addr_t;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_BEQ   = 6'h04,
    OP_ADDI  = 6'h08,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b,
    OP_HALT  = 6'h3f
  } opcode_t;

  // R-type function codes
  localparam funct_t FN_ADD = 6'h20;
  localparam funct_t FN_SUB = 6'h22;
  localparam funct_t FN_AND = 6'h24;
  localparam funct_t FN_OR  = 6'h25;
  localparam funct_t FN_SLT = 6'h2a;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_t;

  typedef enum logic [1:0] {REGFILE, FROM_EX, FROM_MEM, FROM_WB} fwd_sel_t;

  typedef enum logic {IDLE, RESP} axi_state_t;

endpackage

//--- decode/id_stage.sv
module id_stage
  import mips_pkg::*;
(
  input  logic      clk,
  input  logic      i_reset,
  input  logic      i_restart,
  input  word_t     i_pc4,
  input  word_t     i_instr,
  input  reg_addr_t i_wb_rd,
  input  logic      i_wb_reg_write,
  input  word_t     i_wb_value,
  input  fwd_sel_t  i_fwd_a_sel,
  input  fwd_sel_t  i_fwd_b_sel,
  input  word_t     i_ex_value,
  input  word_t     i_mem_value,
  input  logic      i_stall,
  output reg_addr_t o_rs,
  output reg_addr_t o_rt,
  output opcode_t   o_opcode,
  output logic      o_branch_taken,
  output word_t     o_branch_target,
  output logic      o_is_halt,
  output word_t     o_rs_value,
  output word_t     o_rt_value,
  output word_t     o_imm,
  output reg_addr_t o_dest,
  output alu_op_t   o_alu_op,
  output logic      o_alu_src,
  output logic      o_reg_write,
  output logic      o_mem_read,
  output logic      o_mem_write,
  output logic      o_mem_to_reg,
  output reg_addr_t o_ex_rs,
  output reg_addr_t o_ex_rt
);

  word_t     regs [32];
  reg_addr_t rd;
  funct_t    funct;
  imm_t      imm;
  word_t     imm_ext;
  word_t     rs_rf;
  word_t     rt_rf;
  word_t     rs_br;
  word_t     rt_br;
  reg_addr_t dest;
  alu_op_t   alu_op;
  logic      alu_src;
  logic      reg_write;
  logic      mem_read;
  logic      mem_write;

  assign o_opcode = opcode_t'(i_instr[31:26]);
  assign o_rs     = i_instr[25:21];
  assign o_rt     = i_instr[20:16];
  assign rd       = i_instr[15:11];
  assign funct    = i_instr[5:0];
  assign imm      = i_instr[15:0];
  assign imm_ext  = {{16{imm[15]}}, imm};

  // Register file, WB write is visible to a read in the same cycle
  function automatic word_t rf_read(input reg_addr_t addr);
    if (addr == '0) return '0;
    if (i_wb_reg_write && i_wb_rd == addr) return i_wb_value;
    return regs[addr];
  endfunction

  function automatic word_t br_operand(input fwd_sel_t sel, input word_t rf);
    case (sel)
      FROM_EX:  return i_ex_value;
      FROM_MEM: return i_mem_value;
      FROM_WB:  return i_wb_value;
      default:  return rf;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (i_wb_reg_write && i_wb_rd != '0) begin
      regs[i_wb_rd] <= i_wb_value;
    end
  end

  assign rs_rf = rf_read(o_rs);
  assign rt_rf = rf_read(o_rt);
  assign rs_br = br_operand(i_fwd_a_sel, rs_rf);
  assign rt_br = br_operand(i_fwd_b_sel, rt_rf);

  // Stalled beq waits for its operand, no decision yet
  assign o_branch_taken  = (o_opcode == OP_BEQ) && (rs_br == rt_br) && !i_stall;
  assign o_branch_target = i_pc4 + {imm_ext[29:0], 2'b00};
  assign o_is_halt       = (o_opcode == OP_HALT);

  always_comb begin
    dest      = rd;
    alu_op    = ALU_ADD;
    alu_src   = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    case (o_opcode)
      OP_RTYPE: begin
        reg_write = 1'b1;
        case (funct)
          FN_ADD:  alu_op = ALU_ADD;
          FN_SUB:  alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_SLT:  alu_op = ALU_SLT;
          default: reg_write = 1'b0;
        endcase
      end
      OP_ADDI: begin
        dest      = o_rt;
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      OP_LW: begin
        dest      = o_rt;
        alu_src   = 1'b1;
        reg_write = 1'b1;
        mem_read  = 1'b1;
      end
      OP_SW: begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
      end
      default: ;
    endcase
  end

  // ID/EX latch
  always_ff @(posedge clk) begin
    if (i_reset || i_restart || i_stall) begin
      o_reg_write  <= 1'b0;
      o_mem_read   <= 1'b0;
      o_mem_write  <= 1'b0;
      o_mem_to_reg <= 1'b0;
    end else begin
      // r0 destinations never reach writeback
      o_reg_write  <= reg_write && (dest != '0);
      o_mem_read   <= mem_read;
      o_mem_write  <= mem_write;
      o_mem_to_reg <= mem_read;
    end
    o_rs_value <= rs_rf;
    o_rt_value <= rt_rf;
    o_imm      <= imm_ext;
    o_dest     <= dest;
    o_alu_op   <= alu_op;
    o_alu_src  <= alu_src;
    o_ex_rs    <= o_rs;
    o_ex_rt    <= o_rt;
  end

endmodule

//--- execute/ex_stage.sv
module ex_stage
  import mips_pkg::*;
(
  input  logic          clk,
  input  logic          i_reset,
  input  logic          i_restart,
  input  word_t         i_rs_value,
  input  word_t         i_rt_value,
  input  word_t         i_imm,
  input  reg_addr_t     i_dest,
  input  alu_op_t       i_alu_op,
  input  logic          i_alu_src,
  input  logic          i_reg_write,
  input  logic          i_mem_read,
  input  logic          i_mem_write,
  input  logic          i_mem_to_reg,
  input  fwd_sel_t      i_a_sel,
  input  fwd_sel_t      i_b_sel,
  fwd_if.producer_ex    fwd,
  output word_t         o_alu_result,
  output word_t         o_store_data,
  output reg_addr_t     o_rd,
  output logic          o_reg_write,
  output logic          o_mem_read,
  output logic          o_mem_write,
  output logic          o_mem_to_reg
);

  word_t op_a;
  word_t rt_fwd;
  word_t op_b;
  word_t alu_y;

  function automatic word_t operand(input fwd_sel_t sel, input word_t latched);
    case (sel)
      FROM_MEM: return fwd.mem_value;
      FROM_WB:  return fwd.wb_value;
      default:  return latched;
    endcase
  endfunction

  assign op_a   = operand(i_a_sel, i_rs_value);
  assign rt_fwd = operand(i_b_sel, i_rt_value);
  assign op_b   = i_alu_src ? i_imm : rt_fwd;

  always_comb begin
    case (i_alu_op)
      ALU_SUB: alu_y = op_a - op_b;
      ALU_AND: alu_y = op_a & op_b;
      ALU_OR:  alu_y = op_a | op_b;
      ALU_SLT: alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
      default: alu_y = op_a + op_b;
    endcase
  end

  assign fwd.ex_rd        = i_dest;
  assign fwd.ex_reg_write = i_reg_write;
  assign fwd.ex_mem_read  = i_mem_read;
  assign fwd.ex_value     = alu_y;

  // EX/MEM latch
  always_ff @(posedge clk) begin
    if (i_reset || i_restart) begin
      o_reg_write  <= 1'b0;
      o_mem_read   <= 1'b0;
      o_mem_write  <= 1'b0;
      o_mem_to_reg <= 1'b0;
    end else begin
      o_reg_write  <= i_reg_write;
      o_mem_read   <= i_mem_read;
      o_mem_write  <= i_mem_write;
      o_mem_to_reg <= i_mem_to_reg;
    end
    o_alu_result <= alu_y;
    o_store_data <= rt_fwd;
    o_rd         <= i_dest;
  end

endmodule

//--- fetch/if_stage.sv
`include "mips_cfg.svh"

module if_stage
  import mips_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_imem_we,
  input  imem_addr_t i_imem_addr,
  input  word_t      i_imem_data,
  input  logic       i_run,
  input  logic       i_restart,
  input  logic       i_stall,
  input  logic       i_flush,
  input  logic       i_halt,
  input  logic       i_branch_taken,
  input  word_t      i_branch_target,
  output word_t      o_pc4,
  output word_t      o_instr
);

  word_t      imem [`IMEM_WORDS];
  word_t      pc;
  word_t      pc4;
  imem_addr_t fetch_addr;
  logic       hold;

  assign pc4        = pc + 32'd4;
  assign fetch_addr = pc[$bits(imem_addr_t)+1:2];
  assign hold       = i_stall || i_halt || !i_run;

  always_ff @(posedge clk) begin
    if (i_imem_we) imem[i_imem_addr] <= i_imem_data;
  end

  always_ff @(posedge clk) begin
    if (i_reset || i_restart) pc <= '0;
    else if (i_branch_taken) pc <= i_branch_target;
    else if (!hold) pc <= pc4;
  end

  // IF/ID latch, an all-zero word decodes as a bubble
  always_ff @(posedge clk) begin
    if (i_reset || i_restart || i_flush) begin
      o_instr <= '0;
    end else if (!(i_stall || i_halt)) begin
      o_instr <= i_run ? imem[fetch_addr] : '0;
      o_pc4   <= pc4;
    end
  end

endmodule

//--- hdl/forward_unit.sv
module forward_unit
  import mips_pkg::*;
(
  input  reg_addr_t i_id_rs,
  input  reg_addr_t i_id_rt,
  input  reg_addr_t i_ex_rs,
  input  reg_addr_t i_ex_rt,
  fwd_if.consumer   fwd,
  output fwd_sel_t  o_id_a_sel,
  output fwd_sel_t  o_id_b_sel,
  output fwd_sel_t  o_ex_a_sel,
  output fwd_sel_t  o_ex_b_sel
);

  // Checked oldest first so the youngest producer overrides
  function automatic fwd_sel_t pick(input reg_addr_t src, input logic ex_ok);
    fwd_sel_t sel;
    sel = REGFILE;
    if (src != '0) begin
      if (fwd.wb_reg_write && fwd.wb_rd == src) sel = FROM_WB;
      if (fwd.mem_reg_write && fwd.mem_rd == src) sel = FROM_MEM;
      if (ex_ok && fwd.ex_reg_write && fwd.ex_rd == src) sel = FROM_EX;
    end
    return sel;
  endfunction

  always_comb begin
    o_id_a_sel = pick(i_id_rs, 1'b1);
    o_id_b_sel = pick(i_id_rt, 1'b1);
    // EX consumer is itself the EX instruction
    o_ex_a_sel = pick(i_ex_rs, 1'b0);
    o_ex_b_sel = pick(i_ex_rt, 1'b0);
  end

endmodule

//--- hdl/hazard_unit.sv
module hazard_unit
  import mips_pkg::*;
(
  input  logic      clk,
  input  logic      i_reset,
  input  logic      i_restart,
  input  reg_addr_t i_rs,
  input  reg_addr_t i_rt,
  input  opcode_t   i_opcode,
  input  logic      i_is_halt,
  input  logic      i_branch_taken,
  fwd_if.consumer   fwd,
  output logic      o_stall,
  output logic      o_flush,
  output logic      o_halt
);

  logic uses_rs;
  logic uses_rt;
  logic ex_hit;
  logic halt_q;

  assign uses_rs = i_opcode inside {OP_RTYPE, OP_ADDI, OP_LW, OP_SW, OP_BEQ};
  assign uses_rt = i_opcode inside {OP_RTYPE, OP_SW, OP_BEQ};

  assign ex_hit = fwd.ex_reg_write && (fwd.ex_rd != '0) &&
                  ((uses_rs && fwd.ex_rd == i_rs) || (uses_rt && fwd.ex_rd == i_rt));

  // Load data is late for anyone, an ALU result is late for the ID compare
  assign o_stall = ex_hit && (fwd.ex_mem_read || i_opcode == OP_BEQ);
  assign o_flush = i_branch_taken;
  assign o_halt  = halt_q || i_is_halt;

  always_ff @(posedge clk) begin
    if (i_reset || i_restart) halt_q <= 1'b0;
    else if (i_is_halt) halt_q <= 1'b1;
  end

endmodule

//--- hdl/mips_top.sv
module mips_top
  import mips_pkg::*;
(
  input  logic      clk,
  input  logic      i_reset,
  input  logic      i_awvalid,
  output logic      o_awready,
  input  word_t     i_awaddr,
  input  logic      i_wvalid,
  output logic      o_wready,
  input  word_t     i_wdata,
  output logic      o_bvalid,
  input  logic      i_bready,
  output logic      o_wb_valid,
  output reg_addr_t o_wb_reg,
  output word_t     o_wb_data,
  output logic      o_halt
);

  logic       imem_we;
  imem_addr_t imem_addr;
  word_t      imem_data;
  logic       run;
  logic       restart;

  word_t      if_pc4;
  word_t      if_instr;

  reg_addr_t  id_rs;
  reg_addr_t  id_rt;
  opcode_t    id_opcode;
  logic       branch_taken;
  word_t      branch_target;
  logic       id_is_halt;

  // ID/EX bundle
  word_t      idex_rs_value;
  word_t      idex_rt_value;
  word_t      idex_imm;
  reg_addr_t  idex_dest;
  alu_op_t    idex_alu_op;
  logic       idex_alu_src;
  logic       idex_reg_write;
  logic       idex_mem_read;
  logic       idex_mem_write;
  logic       idex_mem_to_reg;
  reg_addr_t  idex_rs;
  reg_addr_t  idex_rt;

  logic       stall;
  logic       flush;
  fwd_sel_t   id_a_sel;
  fwd_sel_t   id_b_sel;
  fwd_sel_t   ex_a_sel;
  fwd_sel_t   ex_b_sel;

  // EX/MEM bundle
  word_t      exm_alu_result;
  word_t      exm_store_data;
  reg_addr_t  exm_rd;
  logic       exm_reg_write;
  logic       exm_mem_read;
  logic       exm_mem_write;
  logic       exm_mem_to_reg;

  fwd_if fwd ();

  prog_loader u_loader (
    .clk(clk), .i_reset(i_reset),
    .i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
    .i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata),
    .o_bvalid(o_bvalid), .i_bready(i_bready),
    .o_imem_we(imem_we), .o_imem_addr(imem_addr), .o_imem_data(imem_data),
    .o_run(run), .o_restart(restart)
  );

  if_stage u_if (
    .clk(clk), .i_reset(i_reset),
    .i_imem_we(imem_we), .i_imem_addr(imem_addr), .i_imem_data(imem_data),
    .i_run(run), .i_restart(restart), .i_stall(stall), .i_flush(flush),
    .i_halt(o_halt), .i_branch_taken(branch_taken), .i_branch_target(branch_target),
    .o_pc4(if_pc4), .o_instr(if_instr)
  );

  id_stage u_id (
    .clk(clk), .i_reset(i_reset), .i_restart(restart),
    .i_pc4(if_pc4), .i_instr(if_instr),
    .i_wb_rd(o_wb_reg), .i_wb_reg_write(o_wb_valid), .i_wb_value(o_wb_data),
    .i_fwd_a_sel(id_a_sel), .i_fwd_b_sel(id_b_sel),
    .i_ex_value(fwd.ex_value), .i_mem_value(fwd.mem_value), .i_stall(stall),
    .o_rs(id_rs), .o_rt(id_rt), .o_opcode(id_opcode),
    .o_branch_taken(branch_taken), .o_branch_target(branch_target),
    .o_is_halt(id_is_halt),
    .o_rs_value(idex_rs_value), .o_rt_value(idex_rt_value), .o_imm(idex_imm),
    .o_dest(idex_dest), .o_alu_op(idex_alu_op), .o_alu_src(idex_alu_src),
    .o_reg_write(idex_reg_write), .o_mem_read(idex_mem_read),
    .o_mem_write(idex_mem_write), .o_mem_to_reg(idex_mem_to_reg),
    .o_ex_rs(idex_rs), .o_ex_rt(idex_rt)
  );

  hazard_unit u_hazard (
    .clk(clk), .i_reset(i_reset), .i_restart(restart),
    .i_rs(id_rs), .i_rt(id_rt), .i_opcode(id_opcode),
    .i_is_halt(id_is_halt), .i_branch_taken(branch_taken), .fwd(fwd.consumer),
    .o_stall(stall), .o_flush(flush), .o_halt(o_halt)
  );

  forward_unit u_forward (
    .i_id_rs(id_rs), .i_id_rt(id_rt), .i_ex_rs(idex_rs), .i_ex_rt(idex_rt),
    .fwd(fwd.consumer),
    .o_id_a_sel(id_a_sel), .o_id_b_sel(id_b_sel),
    .o_ex_a_sel(ex_a_sel), .o_ex_b_sel(ex_b_sel)
  );

  ex_stage u_ex (
    .clk(clk), .i_reset(i_reset), .i_restart(restart),
    .i_rs_value(idex_rs_value), .i_rt_value(idex_rt_value), .i_imm(idex_imm),
    .i_dest(idex_dest), .i_alu_op(idex_alu_op), .i_alu_src(idex_alu_src),
    .i_reg_write(idex_reg_write), .i_mem_read(idex_mem_read),
    .i_mem_write(idex_mem_write), .i_mem_to_reg(idex_mem_to_reg),
    .i_a_sel(ex_a_sel), .i_b_sel(ex_b_sel), .fwd(fwd.producer_ex),
    .o_alu_result(exm_alu_result), .o_store_data(exm_store_data), .o_rd(exm_rd),
    .o_reg_write(exm_reg_write), .o_mem_read(exm_mem_read),
    .o_mem_write(exm_mem_write), .o_mem_to_reg(exm_mem_to_reg)
  );

  mem_wb_stage u_mem_wb (
    .clk(clk), .i_reset(i_reset), .i_restart(restart),
    .i_alu_result(exm_alu_result), .i_store_data(exm_store_data), .i_rd(exm_rd),
    .i_reg_write(exm_reg_write), .i_mem_read(exm_mem_read),
    .i_mem_write(exm_mem_write), .i_mem_to_reg(exm_mem_to_reg),
    .fwd(fwd.producer_mem),
    .o_wb_valid(o_wb_valid), .o_wb_reg(o_wb_reg), .o_wb_data(o_wb_data)
  );

endmodule

//--- hdl/prog_loader.sv
`include "mips_cfg.svh"

module prog_loader
  import mips_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_awvalid,
  output logic       o_awready,
  input  word_t      i_awaddr,
  input  logic       i_wvalid,
  output logic       o_wready,
  input  word_t      i_wdata,
  output logic       o_bvalid,
  input  logic       i_bready,
  output logic       o_imem_we,
  output imem_addr_t o_imem_addr,
  output word_t      o_imem_data,
  output logic       o_run,
  output logic       o_restart
);

  axi_state_t state;
  logic       accept;
  logic       in_imem;

  // Address and data are always taken in the same cycle
  assign accept    = (state == IDLE) && i_awvalid && i_wvalid;
  assign o_awready = accept;
  assign o_wready  = accept;
  assign o_bvalid  = (state == RESP);

  assign in_imem     = i_awaddr < (32'(`IMEM_WORDS) << 2);
  assign o_imem_we   = accept && in_imem;
  assign o_imem_addr = i_awaddr[$bits(imem_addr_t)+1:2];
  assign o_imem_data = i_wdata;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state     <= IDLE;
      o_run     <= 1'b0;
      o_restart <= 1'b0;
    end else begin
      o_restart <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            state <= RESP;
            if (i_awaddr == `CTRL_ADDR) begin
              o_run     <= i_wdata[0];
              o_restart <= i_wdata[0];
            end
          end
        end
        RESP: begin
          if (i_bready) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- memory/mem_wb_stage.sv
`include "mips_cfg.svh"

module mem_wb_stage
  import mips_pkg::*;
(
  input  logic        clk,
  input  logic        i_reset,
  input  logic        i_restart,
  input  word_t       i_alu_result,
  input  word_t       i_store_data,
  input  reg_addr_t   i_rd,
  input  logic        i_reg_write,
  input  logic        i_mem_read,
  input  logic        i_mem_write,
  input  logic        i_mem_to_reg,
  fwd_if.producer_mem fwd,
  output logic        o_wb_valid,
  output reg_addr_t   o_wb_reg,
  output word_t       o_wb_data
);

  word_t      dmem [`DMEM_WORDS];
  dmem_addr_t dmem_idx;
  word_t      load_data;
  word_t      mem_value;

  // Word addressed, low address bits ignored
  assign dmem_idx  = i_alu_result[$bits(dmem_addr_t)+1:2];
  assign load_data = i_mem_read ? dmem[dmem_idx] : '0;
  assign mem_value = i_mem_to_reg ? load_data : i_alu_result;

  always_ff @(posedge clk) begin
    if (i_mem_write) dmem[dmem_idx] <= i_store_data;
  end

  // MEM/WB latch
  always_ff @(posedge clk) begin
    if (i_reset || i_restart) o_wb_valid <= 1'b0;
    else o_wb_valid <= i_reg_write;
    o_wb_reg  <= i_rd;
    o_wb_data <= mem_value;
  end

  assign fwd.mem_rd        = i_rd;
  assign fwd.mem_reg_write = i_reg_write;
  assign fwd.mem_value     = mem_value;
  assign fwd.wb_rd         = o_wb_reg;
  assign fwd.wb_reg_write  = o_wb_valid;
  assign fwd.wb_value      = o_wb_data;

endmodule

//--- sources.f
+incdir+common
common/mips_pkg.sv
common/fwd_if.sv
hdl/prog_loader.sv
fetch/if_stage.sv
decode/id_stage.sv
hdl/hazard_unit.sv
hdl/forward_unit.sv
execute/ex_stage.sv
memory/mem_wb_stage.sv
hdl/mips_top.sv
verif/tb_mips.sv

//--- verif/tb_mips.sv
`include "mips_cfg.svh"

module tb_mips
  import mips_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD     = 4;
  localparam int N_TESTS        = 6;
  localparam int MAX_PROG_WORDS = 9;
  localparam int WATCHDOG_NS    = N_TESTS * (MAX_PROG_WORDS + 50) * CLK_PERIOD;
  localparam int WAIT_CYCLES    = 40;
  localparam word_t HALT_WORD   = {OP_HALT, 26'd0};

  logic      clk = 1'b0;
  logic      reset;
  logic      awvalid;
  logic      awready;
  word_t     awaddr;
  logic      wvalid;
  logic      wready;
  word_t     wdata;
  logic      bvalid;
  logic      bready;
  logic      wb_valid;
  reg_addr_t wb_reg;
  word_t     wb_data;
  logic      halt;

  integer seed = 32'h5a6f;
  int     checks = 0;
  int     errors = 0;
  word_t  prog[$];

  always #(CLK_PERIOD / 2) clk = ~clk;

  mips_top i_dut (
    .clk(clk), .i_reset(reset),
    .i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
    .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata),
    .o_bvalid(bvalid), .i_bready(bready),
    .o_wb_valid(wb_valid), .o_wb_reg(wb_reg), .o_wb_data(wb_data), .o_halt(halt)
  );

  function automatic word_t rtype_word(input funct_t fn, input reg_addr_t rs,
                                       input reg_addr_t rt, input reg_addr_t rd);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t itype_word(input opcode_t op, input reg_addr_t rs,
                                       input reg_addr_t rt, input imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t sext(input imm_t v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t less_signed(input word_t a, input word_t b);
    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
  endfunction

  task automatic check(input word_t actual, input word_t expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Address handshake followed by the write response
  task automatic finish_write();
    int n;
    n = 0;
    @(negedge clk);
    while (!awready && n < WAIT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (!awready) begin
      errors++;
      $display("Write to address %h was never accepted", awaddr);
    end
    check(word_t'(wready), 32'd1, "wready together with awready");
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    @(negedge clk);
    check(word_t'(bvalid), 32'd1, "write response after accept");
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_write(input word_t addr, input word_t data);
    @(posedge clk);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= addr;
    wdata   <= data;
    finish_write();
  endtask

  // Second write is offered while the first response is still waiting for bready
  task automatic write_pair_held(input word_t addr_a, input word_t data_a,
                                 input word_t addr_b, input word_t data_b, input int hold);
    @(posedge clk);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= addr_a;
    wdata   <= data_a;
    @(negedge clk);
    check(word_t'(awready), 32'd1, "first write accepted");
    @(posedge clk);
    awaddr <= addr_b;
    wdata  <= data_b;
    repeat (hold) begin
      @(negedge clk);
      check(word_t'(awready), 32'd0, "awready while response pending");
      check(word_t'(bvalid), 32'd1, "bvalid held without bready");
    end
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
    finish_write();
  endtask

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      axi_write(32'(i * 4), prog[i]);
    end
    prog.delete();
  endtask

  task automatic start();
    axi_write(`CTRL_ADDR, 32'd1);
  endtask

  task automatic expect_wb(input reg_addr_t rd, input word_t value);
    int n;
    n = 0;
    @(negedge clk);
    while (!wb_valid && n < WAIT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (!wb_valid) begin
      errors++;
      $display("No writeback to r%0d within %0d cycles", rd, WAIT_CYCLES);
    end else begin
      check(word_t'(wb_reg), word_t'(rd), $sformatf("writeback register, expected r%0d", rd));
      check(wb_data, value, $sformatf("writeback data of r%0d", rd));
    end
  endtask

  task automatic wait_halt();
    int n;
    n = 0;
    while (!halt && n < WAIT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (!halt) begin
      errors++;
      $display("Halt did not rise within %0d cycles", WAIT_CYCLES);
    end
  endtask

  task automatic quiet_cycles(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check(word_t'(wb_valid), 32'd0, "no writeback after the program");
    end
  endtask

  task automatic alu_sequence();
    word_t va;
    word_t vb;
    imm_t  a;
    imm_t  b;
    a  = imm_t'($random(seed));
    b  = imm_t'($random(seed));
    va = sext(a);
    vb = sext(b);
    prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd1, a));
    prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd2, b));
    prog.push_back(rtype_word(FN_ADD, 5'd1, 5'd2, 5'd3));
    prog.push_back(rtype_word(FN_SUB, 5'd1, 5'd2, 5'd4));
    prog.push_back(rtype_word(FN_AND, 5'd1, 5'd2, 5'd5));
    prog.push_back(rtype_word(FN_OR, 5'd1, 5'd2, 5'd6));
    prog.push_back(rtype_word(FN_SLT, 5'd1, 5'd2, 5'd7));
    prog.push_back(HALT_WORD);
    load_program();
    start();
    expect_wb(5'd1, va);
    expect_wb(5'd2, vb);
    expect_wb(5'd3, va + vb);
    expect_wb(5'd4, va - vb);
    expect_wb(5'd5, va & vb);
    expect_wb(5'd6, va | vb);
    expect_wb(5'd7, less_signed(va, vb));
    wait_halt();
    quiet_cycles(4);
  endtask

  task automatic forwarding_chain();
    word_t v8;
    word_t v9;
    word_t v10;
    word_t v11;
    word_t v12;
    word_t v13;
    imm_t  c;
    imm_t  d;
    imm_t  e;
    c   = imm_t'($random(seed));
    d   = imm_t'($random(seed));
    e   = imm_t'($random(seed));
    v8  = sext(c);
    v9  = v8 + sext(d);
    v10 = v8 + v9;
    v11 = v10 - v8;
    v12 = v11 & v10;
    v13 = less_signed(v12, v11);
    // Consumers one, two and three behind each producer before r8 is redefined
    prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd8, c));
    prog.push_back(itype_word(OP_ADDI, 5'd8, 5'd9, d));
    prog.push_back(rtype_word(FN_ADD, 5'd8, 5'd9, 5'd10));
    prog.push_back(rtype_word(FN_SUB, 5'd10, 5'd8, 5'd11));
    prog.push_back(rtype_word(FN_AND, 5'd11, 5'd10, 5'd12));
    prog.push_back(rtype_word(FN_SLT, 5'd12, 5'd11, 5'd13));
    prog.push_back(itype_word(OP_ADDI, 5'd13, 5'd8, e));
    prog.push_back(rtype_word(FN_ADD, 5'd8, 5'd9, 5'd14));
    prog.push_back(HALT_WORD);
    load_program();
    start();
    expect_wb(5'd8, v8);
    expect_wb(5'd9, v9);
    expect_wb(5'd10, v10);
    expect_wb(5'd11, v11);
    expect_wb(5'd12, v12);
    expect_wb(5'd13, v13);
    expect_wb(5'd8, v13 + sext(e));
    expect_wb(5'd14, v13 + sext(e) + v9);
    wait_halt();
    quiet_cycles(4);
  endtask

  task automatic load_use();
    imm_t x;
    imm_t y;
    x = imm_t'($random(seed));
    y = imm_t'($random(seed));
    prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd1, x));
    prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd2, y));
    prog.push_back(itype_word(OP_SW, 5'd0, 5'd1, 16'd8));
    prog.push_back(itype_word(OP_LW, 5'd0, 5'd3, 16'd8));
    prog.push_back(rtype_word(FN_ADD, 5'd3, 5'd2, 5'd4));
    prog.push_back(HALT_WORD);
    load_program();
    start();
    expect_wb(5'd1, sext(x));
    expect_wb(5'd2, sext(y));
    expect_wb(5'd3, sext(x));
    expect_wb(5'd4, sext(x) + sext(y));
    wait_halt();
    quiet_cycles(4);
  endtask

  task automatic branch_paths();
    imm_t a;
    imm_t b;
    a = imm_t'($random(seed));
    b = a ^ 16'h0001;
    prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd1, a));
    prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd2, a));
    prog.push_back(itype_word(OP_BEQ, 5'd1, 5'd2, 16'd1));
    prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd3, 16'h0111));
    prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd4, b));
    prog.push_back(itype_word(OP_BEQ, 5'd1, 5'd4, 16'd1));
    prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd5, 16'h0333));
    prog.push_back(HALT_WORD);
    load_program();
    start();
    expect_wb(5'd1, sext(a));
    expect_wb(5'd2, sext(a));
    // r3 sits in the branch shadow
    expect_wb(5'd4, sext(b));
    expect_wb(5'd5, 32'h0000_0333);
    wait_halt();
    quiet_cycles(4);
  endtask

  task automatic r0_discard();
    imm_t v;
    imm_t w;
    v = imm_t'($random(seed)) | 16'h0001;
    w = imm_t'($random(seed));
    prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd0, v));
    prog.push_back(rtype_word(FN_ADD, 5'd0, 5'd0, 5'd6));
    prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd7, w));
    prog.push_back(rtype_word(FN_ADD, 5'd7, 5'd0, 5'd8));
    prog.push_back(HALT_WORD);
    load_program();
    start();
    expect_wb(5'd6, 32'd0);
    expect_wb(5'd7, sext(w));
    expect_wb(5'd8, sext(w));
    wait_halt();
    quiet_cycles(4);
  endtask

  task automatic backpressure_restart();
    imm_t a;
    imm_t b;
    a = imm_t'($random(seed));
    b = imm_t'($random(seed));
    write_pair_held(32'd0, itype_word(OP_ADDI, 5'd0, 5'd1, a),
                    32'd4, itype_word(OP_ADDI, 5'd1, 5'd2, b), 6);
    axi_write(32'd8, HALT_WORD);
    for (int pass = 0; pass < 2; pass++) begin
      start();
      @(negedge clk);
      check(word_t'(halt), 32'd0, "halt cleared by restart");
      expect_wb(5'd1, sext(a));
      expect_wb(5'd2, sext(a) + sext(b));
      wait_halt();
      quiet_cycles(3);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    reset   <= 1'b1;
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    awaddr  <= '0;
    wdata   <= '0;
    bready  <= 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check(word_t'(awready), 32'd0, "awready after reset");
    check(word_t'(wready), 32'd0, "wready after reset");
    check(word_t'(bvalid), 32'd0, "bvalid after reset");
    check(word_t'(wb_valid), 32'd0, "wb_valid after reset");
    check(word_t'(halt), 32'd0, "halt after reset");
    alu_sequence();
    forwarding_chain();
    load_use();
    branch_paths();
    r0_discard();
    backpressure_restart();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
